// ==== mcsr.f ====
+incdir+tb
src/csr_map_pkg.sv
src/csr_field_pkg.sv
src/csr_access_if.sv
src/csr_decode.sv
src/csr_rw_field.sv
src/mstatus_ctrl.sv
src/csr_read_mux.sv
src/mcsr.sv
tb/mcsr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the mcsr testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module mcsr_tb \
	-f mcsr.f --Mdir obj_dir -o mcsr_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mcsr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tb/mcsr_model.svh ====
/*
 Reference model of the machine CSR file, included inside mcsr_tb.
 Needs VECTOR_ENTRY and DTCM_START_RESET declared before the include.
 Addresses and bit positions are written out from the register map.
 Not a standalone unit.
*/
`ifndef MCSR_MODEL_SVH
`define MCSR_MODEL_SVH

logic [25:0] m_misa;	// extension bits
logic        m_meie;
logic        m_mtie;
logic [31:0] m_mtvec;	// base and mode as one word
logic        m_tcm;
logic [31:0] m_dtcm;
logic        m_mie;	// mstatus.mie
logic        m_mpie;
logic        m_in_int;	// between interrupt entry and mret

// every implemented address, map order
localparam logic [11:0] MAP_ADDR [13] = '{12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'h300,
	12'h301, 12'h304, 12'h305, 12'h344, 12'h7C0, 12'h7C1, 12'hC01, 12'hC81};

function automatic logic in_map(input logic [11:0] a);
	for (int i = 0; i < 13; i++)
	begin
		if (MAP_ADDR[i] == a)
			return 1'b1;
	end
	return 1'b0;
endfunction

function automatic logic is_id(input logic [11:0] a);
	return a inside {12'hF11, 12'hF12, 12'hF13, 12'hF14};
endfunction

function automatic logic illegal(input logic [11:0] a, input logic rd, input logic wr);
	return ((rd || wr) && !in_map(a)) || (wr && is_id(a));
endfunction

// write, set, clear; code 3 writes
function automatic logic [31:0] op_apply(input logic [31:0] cur, input logic [31:0] d,
	input logic [1:0] op);
	case (op)
		2'b01:   return cur | d;
		2'b10:   return cur & ~d;
		default: return d;
	endcase
endfunction

// architectural read value, live lines passed in
function automatic logic [31:0] model_read(input logic [11:0] a, input logic ext,
	input logic tmr, input logic [63:0] t);
	case (a)
		12'hF13: return 32'h1000_0000;	// mimpid, other ids zero
		12'h300: return {24'b0, m_mpie, 3'b0, m_mie, 3'b0};
		12'h301: return {2'b01, 4'b0, m_misa};	// mxl 32 bit
		12'h304: return {20'b0, m_meie, 3'b0, m_mtie, 7'b0};
		12'h305: return m_mtvec;
		12'h344: return {20'b0, ext, 3'b0, tmr, 7'b0};
		12'h7C0: return {31'b0, m_tcm};
		12'h7C1: return m_dtcm;
		12'hC01: return t[31:0];
		12'hC81: return t[63:32];
		default: return 32'h0;
	endcase
endfunction

task automatic model_reset();
	m_misa   = 26'h100;
	m_meie   = 1'b1;
	m_mtie   = 1'b1;
	m_mtvec  = {VECTOR_ENTRY[31:2], 2'b00};	// mode 0 after reset
	m_tcm    = 1'b1;
	m_dtcm   = DTCM_START_RESET;
	m_mie    = 1'b0;
	m_mpie   = 1'b0;
	m_in_int = 1'b0;
endtask

// one rising edge with the inputs of that cycle
task automatic model_clock(input logic [11:0] a, input logic wr, input logic [1:0] op,
	input logic [31:0] d, input logic vi, input logic mr);
	logic        ok;
	logic [31:0] n;
	ok = wr && !illegal(a, 1'b0, wr);
	if (ok)
	begin
		case (a)
			12'h301:
			begin
				n = op_apply({6'b0, m_misa}, d, op);
				m_misa = n[25:0];
			end
			12'h304:
			begin
				n = op_apply({20'b0, m_meie, 3'b0, m_mtie, 7'b0}, d, op);
				m_meie = n[11];
				m_mtie = n[7];
			end
			12'h305: m_mtvec = op_apply(m_mtvec, d, op);	// base from bits 31:2
			12'h7C0:
			begin
				n = op_apply({31'b0, m_tcm}, d, op);
				m_tcm = n[0];
			end
			12'h7C1: m_dtcm = op_apply(m_dtcm, d, op);
			default: n = '0;	// mstatus below, mip and time ignore writes
		endcase
	end
	if (mr && m_in_int)
	begin
		m_mie    = m_mpie;	// restore first
		m_mpie   = 1'b1;
		m_in_int = 1'b0;
	end
	else if (vi)
	begin
		m_mpie   = m_mie;
		m_mie    = 1'b0;
		m_in_int = 1'b1;
	end
	else if (ok && a == 12'h300)
	begin
		n = op_apply({24'b0, m_mpie, 3'b0, m_mie, 3'b0}, d, op);
		m_mie  = n[3];
		m_mpie = n[7];
	end
endtask

`endif

// ==== tb/mcsr_tb.sv ====
/*
 Self-checking testbench of the machine CSR file.
 Random stimulus from a fixed seed, checked against the model in
 mcsr_model.svh. Inputs change on the falling edge, outputs are
 sampled a quarter period later, the model steps on the rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module mcsr_tb;
	import csr_map_pkg::*;
	import csr_field_pkg::*;

	localparam csr_data_t VECTOR_ENTRY     = 32'h8000_0103;	// low bits dropped by mtvec
	localparam csr_data_t DTCM_START_RESET = 32'h0002_0000;
	localparam int        WATCHDOG_CYCLES  = 5000;
	localparam csr_addr_t RW_ADDR [6] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h7C0, 12'h7C1};

	logic       cpu_clk;
	logic       cpu_rstn;
	csr_addr_t  csr_addr;
	logic       csr_rd;
	logic       csr_wr;
	csr_op_e    csr_op;
	csr_data_t  write_data;
	logic       meip;
	logic       mtip;
	logic       valid_interrupt;
	logic       mret;
	mtime_t     mtime;
	csr_data_t  read_data;
	logic       csr_illegal_access;
	logic       meie;
	logic       mtie;
	logic       mstatus_mie;
	logic [1:0] mtvec_mode;
	csr_data_t  mtvec_base;
	logic       dtcm_en;
	csr_data_t  dtcm_start_addr;

	logic   line_meip;	// next values of the live inputs
	logic   line_mtip;
	mtime_t line_mtime;

	int seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int err_at_start;

	`include "mcsr_model.svh"

	mcsr #(
		.VECTOR_ENTRY     (VECTOR_ENTRY),
		.DTCM_START_RESET (DTCM_START_RESET)
	) mcsr_i (
		.cpu_clk            (cpu_clk),
		.cpu_rstn           (cpu_rstn),
		.csr_addr           (csr_addr),
		.csr_rd             (csr_rd),
		.csr_wr             (csr_wr),
		.csr_op             (csr_op),
		.write_data         (write_data),
		.read_data          (read_data),
		.csr_illegal_access (csr_illegal_access),
		.meip               (meip),
		.mtip               (mtip),
		.valid_interrupt    (valid_interrupt),
		.mret               (mret),
		.mtime              (mtime),
		.meie               (meie),
		.mtie               (mtie),
		.mstatus_mie        (mstatus_mie),
		.mtvec_mode         (mtvec_mode),
		.mtvec_base         (mtvec_base),
		.dtcm_en            (dtcm_en),
		.dtcm_start_addr    (dtcm_start_addr)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #10 cpu_clk = ~cpu_clk;	// 20 ns
	end

	// hard stop if the sequence ever stalls
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge cpu_clk);
		$display("run went past %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// register outputs against model state
	task automatic check_ports(input string name);
		check_flag({name, " meie"}, m_meie, meie);
		check_flag({name, " mtie"}, m_mtie, mtie);
		check_flag({name, " mstatus_mie"}, m_mie, mstatus_mie);
		check_flag({name, " dtcm_en"}, m_tcm, dtcm_en);
		check_data({name, " mtvec_mode"}, {30'b0, m_mtvec[1:0]}, {30'b0, mtvec_mode});
		check_data({name, " mtvec_base"}, {m_mtvec[31:2], 2'b00}, mtvec_base);
		check_data({name, " dtcm_start"}, m_dtcm, dtcm_start_addr);
	endtask

	// one cycle: drive, check same-cycle outputs, step model
	task automatic csr_access(input string name, input csr_addr_t a, input logic rd,
		input logic wr, input csr_op_e op, input csr_data_t d, input logic vi, input logic mr);
		logic      exp_ill;
		csr_data_t exp_rd;
		@(negedge cpu_clk);
		check_ports(name);
		csr_addr        = a;
		csr_rd          = rd;
		csr_wr          = wr;
		csr_op          = op;
		write_data      = d;
		valid_interrupt = vi;
		mret            = mr;
		meip            = line_meip;
		mtip            = line_mtip;
		mtime           = line_mtime;
		#5;
		exp_ill = illegal(a, rd, wr);
		exp_rd  = (rd && !exp_ill) ? model_read(a, meip, mtip, mtime) : '0;
		check_flag({name, " illegal"}, exp_ill, csr_illegal_access);
		check_data({name, " read"}, exp_rd, read_data);
		@(posedge cpu_clk);
		model_clock(a, wr, op, d, vi, mr);
	endtask

	task automatic read_all(input string name);
		for (int i = 0; i < 13; i++)
			csr_access($sformatf("%s %03h", name, MAP_ADDR[i]), MAP_ADDR[i], 1'b1, 1'b0,
				WRITE, '0, 1'b0, 1'b0);
	endtask

	task automatic wait_reset_ports();
		int n;
		n = 0;
		while (!(dtcm_en === 1'b1 && meie === 1'b1 && mtie === 1'b1) && n < 8)
		begin
			@(negedge cpu_clk);
			n++;
		end
		if (!(dtcm_en === 1'b1 && meie === 1'b1 && mtie === 1'b1))
		begin
			errors++;
			$display("output ports never showed their reset state");
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_at_start)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_at_start);
		end
		err_at_start = errors;
	endtask

	initial
	begin
		csr_addr_t   a;
		csr_data_t   d;
		logic [31:0] r32;
		logic [1:0]  r2;
		seed         = 32'h80adf7a3;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		err_at_start = 0;
		cpu_rstn        = 1'b0;
		csr_addr        = '0;
		csr_rd          = 1'b0;
		csr_wr          = 1'b0;
		csr_op          = WRITE;
		write_data      = '0;
		meip            = 1'b0;
		mtip            = 1'b0;
		valid_interrupt = 1'b0;
		mret            = 1'b0;
		mtime           = '0;
		line_meip       = 1'b0;
		line_mtip       = 1'b0;
		line_mtime      = '0;
		model_reset();
		repeat (16) @(negedge cpu_clk);
		cpu_rstn = 1'b1;

		wait_reset_ports();
		read_all("reset");
		end_test("reset");

		for (int i = 0; i < 300; i++)
		begin
			r32 = $random(seed);
			a   = RW_ADDR[r32 % 6];
			r2  = r32[9:8];
			d   = $random(seed);
			csr_access("rw write", a, 1'b0, 1'b1, csr_op_e'(r2), d, 1'b0, 1'b0);
			csr_access("rw readback", a, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
		end
		end_test("rw_random");

		for (int i = 0; i < 40; i++)
		begin
			r32 = $random(seed);
			a   = r32[11:0];
			if (in_map(a))
				a = 12'h7FF;	// outside the map
			d = $random(seed);
			csr_access("unknown read", a, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
			csr_access("unknown write", a, r32[12], 1'b1, csr_op_e'(r32[14:13]), d, 1'b0, 1'b0);
		end
		for (int i = 0; i < 4; i++)
		begin
			r32 = $random(seed);
			csr_access("id write", MAP_ADDR[i], r32[0], 1'b1, csr_op_e'(r32[2:1]), r32,
				1'b0, 1'b0);
		end
		read_all("after illegal");
		end_test("illegal");

		csr_access("mret idle", 12'h300, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b1);	// not in irq
		for (int i = 0; i < 200; i++)
		begin
			r32 = $random(seed);
			d   = $random(seed);
			csr_access("irq mstatus", 12'h300, 1'b1, r32[0] & r32[1], csr_op_e'(r32[3:2]), d,
				r32[4] & r32[5], r32[6]);
		end
		end_test("irq_mstatus");

		for (int i = 0; i < 30; i++)
		begin
			r32        = $random(seed);
			line_meip  = r32[0];
			line_mtip  = r32[1];
			line_mtime = {$random(seed), $random(seed)};
			csr_access("mip", 12'h344, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
			csr_access("time", 12'hC01, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
			csr_access("timeh", 12'hC81, 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
		end
		for (int i = 0; i < 4; i++)
			csr_access("id read", MAP_ADDR[i], 1'b1, 1'b0, WRITE, '0, 1'b0, 1'b0);
		end_test("live_inputs");

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mcsr.sv ====
/*
 Machine-level CSR file of a small RV32 core, no debug support.
 One access per cycle: read data and csr_illegal_access are
 combinational, writes take effect at the next cpu_clk edge.
 mepc/mcause/mtval and PMP/S-mode CSRs are not here and decode
 as illegal. No back-pressure, every access is accepted.
*/
`timescale 1ns/1ps
`default_nettype none

module mcsr #(
	parameter csr_field_pkg::csr_data_t VECTOR_ENTRY     = 32'h0000_0000,	// mtvec reset
	parameter csr_field_pkg::csr_data_t DTCM_START_RESET = 32'h0010_0000
) (
	input  wire                           cpu_clk,
	input  wire                           cpu_rstn,
	// decoder side
	input  wire csr_map_pkg::csr_addr_t   csr_addr,
	input  wire                           csr_rd,
	input  wire                           csr_wr,
	input  wire csr_map_pkg::csr_op_e     csr_op,
	input  wire csr_field_pkg::csr_data_t write_data,
	output csr_field_pkg::csr_data_t      read_data,
	output logic                          csr_illegal_access,
	// trap controller side
	input  wire                           meip,
	input  wire                           mtip,
	input  wire                           valid_interrupt,
	input  wire                           mret,
	input  wire csr_field_pkg::mtime_t    mtime,
	output logic                          meie,
	output logic                          mtie,
	output logic                          mstatus_mie,
	output logic [1:0]                    mtvec_mode,
	output csr_field_pkg::csr_data_t      mtvec_base,	// bits 1:0 zero
	// memory controller side
	output logic                          dtcm_en,
	output csr_field_pkg::csr_data_t      dtcm_start_addr
);
	import csr_map_pkg::*;
	import csr_field_pkg::*;

	localparam mtvec_t MTVEC_RESET = '{base: VECTOR_ENTRY[31:MTVEC_BASE_LSB], mode: 2'b00};

	misa_ext_t misa_q;
	mie_bits_t mie_q;
	mie_bits_t mie_wr;	// enable bits picked from write_data
	mtvec_t    mtvec_q;
	logic      mstatus_mpie;

	csr_access_if acc ();

	csr_decode decode_i (
		.csr_addr           (csr_addr),
		.csr_rd             (csr_rd),
		.csr_wr             (csr_wr),
		.csr_op             (csr_op),
		.write_data         (write_data),
		.csr_illegal_access (csr_illegal_access),
		.acc                (acc)
	);

	// misa, extensions only
	csr_rw_field #(.field_t(misa_ext_t), .RESET_VALUE(MISA_EXT_RESET)) misa_i (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_en    (acc.wr_en[MISA]),
		.op       (acc.op),
		.wr_field (write_data[$bits(misa_ext_t)-1:0]),
		.q        (misa_q)
	);

	assign mie_wr = '{meie: write_data[MEIE_BIT], mtie: write_data[MTIE_BIT]};

	csr_rw_field #(.field_t(mie_bits_t), .RESET_VALUE(2'b11)) mie_i (	// both enabled
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_en    (acc.wr_en[MIE]),
		.op       (acc.op),
		.wr_field (mie_wr),
		.q        (mie_q)
	);

	// base always from write_data 31:2
	csr_rw_field #(.field_t(mtvec_t), .RESET_VALUE(MTVEC_RESET)) mtvec_i (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_en    (acc.wr_en[MTVEC]),
		.op       (acc.op),
		.wr_field (mtvec_t'(write_data)),
		.q        (mtvec_q)
	);

	csr_rw_field #(.field_t(logic), .RESET_VALUE(1'b1)) tcm_en_i (	// dtcm on after reset
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_en    (acc.wr_en[TCM_CTRL]),
		.op       (acc.op),
		.wr_field (write_data[TCM_EN_BIT]),
		.q        (dtcm_en)
	);

	csr_rw_field #(.field_t(csr_data_t), .RESET_VALUE(DTCM_START_RESET)) dtcm_start_i (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_en    (acc.wr_en[DTCM_START]),
		.op       (acc.op),
		.wr_field (write_data),
		.q        (dtcm_start_addr)
	);

	mstatus_ctrl mstatus_i (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.acc             (acc),
		.valid_interrupt (valid_interrupt),
		.mret            (mret),
		.mstatus_mie     (mstatus_mie),
		.mstatus_mpie    (mstatus_mpie)
	);

	csr_read_mux read_mux_i (
		.acc             (acc),
		.misa            (misa_q),
		.mstatus_mie     (mstatus_mie),
		.mstatus_mpie    (mstatus_mpie),
		.mie             (mie_q),
		.mtvec           (mtvec_q),
		.meip            (meip),
		.mtip            (mtip),
		.dtcm_en         (dtcm_en),
		.dtcm_start_addr (dtcm_start_addr),
		.mtime           (mtime),
		.read_data       (read_data)
	);

	assign meie       = mie_q.meie;
	assign mtie       = mie_q.mtie;
	assign mtvec_mode = mtvec_q.mode;
	assign mtvec_base = {mtvec_q.base, {MTVEC_BASE_LSB{1'b0}}};	// word aligned

endmodule

`default_nettype wire

// ==== src/csr_read_mux.sv ====
/*
 Read value of the selected CSR, same cycle.
 mip, time and timeh come straight from the input lines.
 Output is zero unless the access is a legal read.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
	csr_access_if.rdmux                    acc,
	input  wire csr_field_pkg::misa_ext_t  misa,
	input  wire                            mstatus_mie,
	input  wire                            mstatus_mpie,
	input  wire csr_field_pkg::mie_bits_t  mie,
	input  wire csr_field_pkg::mtvec_t     mtvec,
	input  wire                            meip,	// external irq line
	input  wire                            mtip,	// timer irq line
	input  wire                            dtcm_en,
	input  wire csr_field_pkg::csr_data_t  dtcm_start_addr,
	input  wire csr_field_pkg::mtime_t     mtime,
	output csr_field_pkg::csr_data_t       read_data
);
	import csr_map_pkg::*;
	import csr_field_pkg::*;

	csr_data_t val [CSR_N];	// architectural view per csr
	csr_data_t sel_or;

	// place fields at their bit positions
	always_comb
	begin
		val = '{default: '0};
		val[MVENDORID] = MVENDORID_VALUE;
		val[MARCHID]   = MARCHID_VALUE;
		val[MIMPID]    = MIMPID_VALUE;
		val[MHARTID]   = MHARTID_VALUE;
		val[MSTATUS][MSTATUS_MIE_BIT]  = mstatus_mie;
		val[MSTATUS][MSTATUS_MPIE_BIT] = mstatus_mpie;
		val[MISA] = {MISA_MXL, 4'h0, misa};	// mxl in 31:30
		val[MIE][MEIE_BIT] = mie.meie;
		val[MIE][MTIE_BIT] = mie.mtie;
		val[MTVEC] = csr_data_t'(mtvec);	// base|mode
		val[MIP][MEIP_BIT] = meip;
		val[MIP][MTIP_BIT] = mtip;
		val[TCM_CTRL][TCM_EN_BIT] = dtcm_en;
		val[DTCM_START] = dtcm_start_addr;
		val[TIME]  = mtime[31:0];
		val[TIMEH] = mtime[63:32];
	end

	// and-or mux, sel is one-hot
	always_comb
	begin
		sel_or = '0;
		for (int i = 0; i < CSR_N; i++)
		begin
			if (acc.sel[i])
				sel_or = sel_or | val[i];
		end
	end

	assign read_data = acc.rd_en ? sel_or : '0;	// zero on illegal or no read

endmodule

`default_nettype wire

// ==== src/mstatus_ctrl.sv ====
/*
 mstatus MIE/MPIE and the in-interrupt flag.
 Priority per cycle: mret (only while in an interrupt), then
 interrupt entry, then a CSR write. mret outside an interrupt
 is ignored. Nested interrupts are not tracked.
*/
`timescale 1ns/1ps
`default_nettype none

module mstatus_ctrl (
	input  wire        cpu_clk,
	input  wire        cpu_rstn,
	csr_access_if.regs acc,
	input  wire        valid_interrupt,	// trap taken this cycle
	input  wire        mret,	// mret retires this cycle
	output logic       mstatus_mie,
	output logic       mstatus_mpie
);
	import csr_map_pkg::*;
	import csr_field_pkg::*;

	logic in_int;	// between entry and mret
	logic wr;
	logic mie_nxt;
	logic mpie_nxt;

	// single bit write/set/clear
	function automatic logic apply_op(input logic cur, input logic d, input csr_op_e op);
		case (op)
			SET:     return cur | d;
			CLEAR:   return cur & ~d;
			default: return d;
		endcase
	endfunction

	assign wr       = acc.wr_en[MSTATUS];
	assign mie_nxt  = apply_op(mstatus_mie, acc.wdata[MSTATUS_MIE_BIT], acc.op);
	assign mpie_nxt = apply_op(mstatus_mpie, acc.wdata[MSTATUS_MPIE_BIT], acc.op);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			in_int       <= 1'b0;
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end
		else if (mret && in_int)
		begin
			mstatus_mie  <= mstatus_mpie;	// restore
			mstatus_mpie <= 1'b1;
			in_int       <= 1'b0;
		end
		else if (valid_interrupt)
		begin
			mstatus_mpie <= mstatus_mie;	// stash
			mstatus_mie  <= 1'b0;	// block further irqs
			in_int       <= 1'b1;
		end
		else if (wr)
		begin
			mstatus_mie  <= mie_nxt;
			mstatus_mpie <= mpie_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== src/csr_rw_field.sv ====
/*
 One CSR field register with write, set and clear.
 field_t is any packed type; set and clear work bitwise over it.
 The spare op code behaves as a plain write.
 Update lands on the rising edge after wr_en.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_rw_field #(
	parameter type    field_t     = logic,
	parameter field_t RESET_VALUE = '0
) (
	input  wire                       cpu_clk,
	input  wire                       cpu_rstn,
	input  wire                       wr_en,	// legal write to this csr
	input  wire csr_map_pkg::csr_op_e op,
	input  wire field_t               wr_field,	// write data, already sliced
	output field_t                    q
);
	import csr_map_pkg::*;

	field_t nxt;

	// next value for the selected op
	always_comb
	begin
		case (op)
			SET:     nxt = field_t'(q | wr_field);
			CLEAR:   nxt = field_t'(q & ~wr_field);
			default: nxt = wr_field;	// write, spare code
		endcase
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			q <= RESET_VALUE;
		else if (wr_en)
			q <= nxt;	// hold otherwise
	end

endmodule

`default_nettype wire

// ==== src/csr_decode.sv ====
/*
 Address decode and access check, combinational.
 Illegal: a strobe to an unknown address, or a write to an ID
 register. An illegal access raises no strobe at all, so the
 register blocks never need to check legality again.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
	input  wire csr_map_pkg::csr_addr_t   csr_addr,
	input  wire                           csr_rd,
	input  wire                           csr_wr,
	input  wire csr_map_pkg::csr_op_e     csr_op,
	input  wire csr_field_pkg::csr_data_t write_data,
	output logic                          csr_illegal_access,
	csr_access_if.decoder                 acc
);
	import csr_map_pkg::*;

	csr_sel_t sel;
	logic     hit;	// address exists
	logic     ro_hit;	// one of the id regs
	logic     illegal;

	// address to one-hot
	always_comb
	begin
		sel = '0;
		case (csr_addr)
			MVENDORID_ADDR:  sel[MVENDORID]  = 1'b1;
			MARCHID_ADDR:    sel[MARCHID]    = 1'b1;
			MIMPID_ADDR:     sel[MIMPID]     = 1'b1;
			MHARTID_ADDR:    sel[MHARTID]    = 1'b1;
			MSTATUS_ADDR:    sel[MSTATUS]    = 1'b1;
			MISA_ADDR:       sel[MISA]       = 1'b1;
			MIE_ADDR:        sel[MIE]        = 1'b1;
			MTVEC_ADDR:      sel[MTVEC]      = 1'b1;
			MIP_ADDR:        sel[MIP]        = 1'b1;
			TCM_CTRL_ADDR:   sel[TCM_CTRL]   = 1'b1;
			DTCM_START_ADDR: sel[DTCM_START] = 1'b1;
			TIME_ADDR:       sel[TIME]       = 1'b1;
			TIMEH_ADDR:      sel[TIMEH]      = 1'b1;
			default:         sel = '0;	// unknown, incl. mepc/mcause/mtval
		endcase
	end

	assign hit    = |sel;
	assign ro_hit = sel[MVENDORID] | sel[MARCHID] | sel[MIMPID] | sel[MHARTID];

	// unknown address, or write to read-only id
	assign illegal = ((csr_rd | csr_wr) & ~hit) | (csr_wr & ro_hit);
	assign csr_illegal_access = illegal;

	assign acc.sel   = sel;
	assign acc.wr_en = (csr_wr & ~illegal) ? sel : '0;	// mip/time writes land nowhere
	assign acc.rd_en = csr_rd & ~illegal;	// hit implied
	assign acc.op    = csr_op;
	assign acc.wdata = write_data;

endmodule

`default_nettype wire

// ==== src/csr_access_if.sv ====
/*
 Decoded CSR access, from the decoder to the register blocks and
 the read mux. wr_en is one-hot and only set for a legal write;
 rd_en only for a legal read. Purely combinational signals.
*/
`timescale 1ns/1ps
`default_nettype none

interface csr_access_if;
	import csr_map_pkg::*;
	import csr_field_pkg::*;

	csr_sel_t  sel;	// address match, one-hot or zero
	csr_sel_t  wr_en;	// qualified write strobe per csr
	logic      rd_en;	// qualified read
	csr_op_e   op;	// write, set or clear
	csr_data_t wdata;

	modport decoder (output sel, output wr_en, output rd_en, output op, output wdata);
	modport regs (input wr_en, input op, input wdata);
	modport rdmux (input sel, input rd_en);

endinterface

`default_nettype wire

// ==== src/csr_field_pkg.sv ====
/*
 Data types and field layout of the machine CSRs, RV32 only.
 Only MIE/MPIE of mstatus, MEIE/MTIE of mie and MEIP/MTIP of mip
 exist; all other bits read as zero and ignore writes.
 misa reads back with MXL = 1 in bits 31:30.
*/
`default_nettype none

package csr_field_pkg;

	typedef logic [31:0] csr_data_t;
	typedef logic [63:0] mtime_t;	// from the machine timer
	typedef logic [25:0] misa_ext_t;	// extension bits Z..A

	localparam misa_ext_t MISA_EXT_RESET = 26'h000_0100;	// I base only
	localparam logic [1:0] MISA_MXL      = 2'b01;	// 32 bit

	// architectural bit positions
	localparam int unsigned MSTATUS_MIE_BIT  = 3;
	localparam int unsigned MSTATUS_MPIE_BIT = 7;
	localparam int unsigned MTIE_BIT         = 7;
	localparam int unsigned MTIP_BIT         = 7;
	localparam int unsigned MEIE_BIT         = 11;
	localparam int unsigned MEIP_BIT         = 11;
	localparam int unsigned MTVEC_BASE_LSB   = 2;	// mode in 1:0
	localparam int unsigned TCM_EN_BIT       = 0;	// dtcm enable

	// enable bits kept in mie
	typedef struct packed {
		logic meie;	// external
		logic mtie;	// timer
	} mie_bits_t;

	// layout matches the csr word, so a cast maps it directly
	typedef struct packed {
		logic [31:MTVEC_BASE_LSB]   base;
		logic [MTVEC_BASE_LSB-1:0] mode;	// 0 direct, 1 vectored
	} mtvec_t;

	// fixed ids
	localparam csr_data_t MVENDORID_VALUE = 32'h0000_0000;	// non-commercial
	localparam csr_data_t MARCHID_VALUE   = 32'h0000_0000;
	localparam csr_data_t MIMPID_VALUE    = 32'h1000_0000;
	localparam csr_data_t MHARTID_VALUE   = 32'h0000_0000;	// single hart

endpackage

`default_nettype wire

// ==== src/csr_map_pkg.sv ====
/*
 CSR address map of the machine-level register file, one hart.
 Only the thirteen CSRs listed here exist; any other address is
 reported as illegal, including mepc/mcause/mtval (trap controller).
 Address constants carry an _ADDR suffix so they do not clash with
 the select index labels.
*/
`default_nettype none

package csr_map_pkg;

	typedef logic [11:0] csr_addr_t;	// csr field of the instruction

	// bit order of the one-hot select
	typedef enum logic [3:0] {
		MVENDORID,
		MARCHID,
		MIMPID,
		MHARTID,
		MSTATUS,
		MISA,
		MIE,
		MTVEC,
		MIP,
		TCM_CTRL,
		DTCM_START,
		TIME,
		TIMEH
	} csr_idx_e;

	localparam int unsigned CSR_N = 13;	// implemented csrs

	typedef logic [CSR_N-1:0] csr_sel_t;	// one bit per csr_idx_e

	localparam csr_addr_t MVENDORID_ADDR  = 12'hF11;	// ro
	localparam csr_addr_t MARCHID_ADDR    = 12'hF12;	// ro
	localparam csr_addr_t MIMPID_ADDR     = 12'hF13;	// ro
	localparam csr_addr_t MHARTID_ADDR    = 12'hF14;	// ro
	localparam csr_addr_t MSTATUS_ADDR    = 12'h300;
	localparam csr_addr_t MISA_ADDR       = 12'h301;
	localparam csr_addr_t MIE_ADDR        = 12'h304;
	localparam csr_addr_t MTVEC_ADDR      = 12'h305;
	localparam csr_addr_t MIP_ADDR        = 12'h344;	// live lines, writes ignored
	localparam csr_addr_t TCM_CTRL_ADDR   = 12'h7C0;	// custom
	localparam csr_addr_t DTCM_START_ADDR = 12'h7C1;	// custom
	localparam csr_addr_t TIME_ADDR       = 12'hC01;	// mtime low word
	localparam csr_addr_t TIMEH_ADDR      = 12'hC81;	// mtime high word

	// access kind from the decoder
	typedef enum logic [1:0] {
		WRITE = 2'b00,	// csrrw
		SET   = 2'b01,	// csrrs, or in
		CLEAR = 2'b10	// csrrc, and with inverted data
	} csr_op_e;	// 2'b11 acts as write

endpackage

`default_nettype wire
